//--- common/eth_rx_cfg.svh
`ifndef ETH_RX_CFG_SVH
`define ETH_RX_CFG_SVH

// ==============================
// receive path sizing
// ==============================

// beats held in the output FIFO, power of two
`define RX_FIFO_DEPTH 64

// beats the sink can take after reset
`define RX_CREDITS_INIT 4

// shortest frame that delivers a beat, FCS included
// also the length of the FCS delay line
`define RX_MIN_FRAME 5

`endif

//--- common/eth_rx_pkg.sv
`default_nettype none

package eth_rx_pkg;

    // ==============================
    // byte and beat formats
    // ==============================

    // one assembled byte from the MII decoder
    typedef struct packed {
        logic [7:0] data;
        // first byte after the SFD
        logic       sof;
        // rx_dv fell after this byte
        logic       eof;
        // rx_er seen on a nibble of this byte
        logic       err;
    } mii_byte_t;

    // one payload byte handed downstream
    typedef struct packed {
        logic [7:0] data;
        logic       sop;
        logic       eop;
        // frame status, valid with eop only
        logic       bad;
    } eth_beat_t;

    // ==============================
    // crc-32
    // ==============================

    // reflected IEEE 802.3 polynomial
    parameter logic [31:0] CRC32_POLY    = 32'hEDB8_8320;

    // register value after a good frame and its FCS
    parameter logic [31:0] CRC32_RESIDUE = 32'hDEBB_20E3;

endpackage

`default_nettype wire

//--- mii_rx/mii_nibble_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mii_nibble_decoder (
    input  wire                   rx_clk,
    input  wire                   rst_n,
    input  wire                   rx_dv,
    input  wire                   rx_er,
    input  wire [3:0]             rxd,
    output eth_rx_pkg::mii_byte_t byte_out,
    output logic                  byte_valid,
    output logic                  frame_end,
    output logic                  frame_end_odd
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_SFD,
        ST_DATA
    } state_t;

    state_t     state;
    logic [3:0] low_nib;
    logic       low_err;
    logic       hi_next;
    logic       first;

    always_ff @(posedge rx_clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            low_nib       <= 4'h0;
            low_err       <= 1'b0;
            hi_next       <= 1'b0;
            first         <= 1'b0;
            byte_out      <= '0;
            byte_valid    <= 1'b0;
            frame_end     <= 1'b0;
            frame_end_odd <= 1'b0;
        end else begin
            byte_valid    <= 1'b0;
            frame_end     <= 1'b0;
            frame_end_odd <= 1'b0;
            byte_out.eof  <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (rx_dv && rxd == 4'h5) begin
                        state <= ST_PREAMBLE;
                    end
                end

                // any run of 5 nibbles, then D
                ST_PREAMBLE: begin
                    if (!rx_dv) begin
                        state <= ST_IDLE;
                    end else if (rxd == 4'hD) begin
                        state <= ST_SFD;
                    end else if (rxd != 4'h5) begin
                        state <= ST_IDLE;
                    end
                end

                // low nibble of the first byte
                ST_SFD: begin
                    if (!rx_dv) begin
                        frame_end    <= 1'b1;
                        byte_out.sof <= 1'b0;
                        byte_out.eof <= 1'b1;
                        byte_out.err <= 1'b0;
                        state        <= ST_IDLE;
                    end else begin
                        low_nib <= rxd;
                        low_err <= rx_er;
                        hi_next <= 1'b1;
                        first   <= 1'b1;
                        state   <= ST_DATA;
                    end
                end

                ST_DATA: begin
                    if (!rx_dv) begin
                        // a held low nibble means an odd count
                        frame_end     <= 1'b1;
                        frame_end_odd <= hi_next;
                        byte_out.sof  <= 1'b0;
                        byte_out.eof  <= 1'b1;
                        byte_out.err  <= hi_next & low_err;
                        state         <= ST_IDLE;
                    end else if (hi_next) begin
                        byte_out.data <= {rxd, low_nib};
                        byte_out.sof  <= first;
                        byte_out.err  <= low_err | rx_er;
                        byte_valid    <= 1'b1;
                        first         <= 1'b0;
                        hi_next       <= 1'b0;
                    end else begin
                        low_nib <= rxd;
                        low_err <= rx_er;
                        hi_next <= 1'b1;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/frame_crc_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_cfg.svh"

module frame_crc_checker (
    input  wire                        rx_clk,
    input  wire                        rst_n,
    input  wire eth_rx_pkg::mii_byte_t byte_in,
    input  wire                        byte_valid,
    input  wire                        frame_end,
    input  wire                        frame_end_odd,
    output eth_rx_pkg::eth_beat_t      beat,
    output logic                       beat_valid
);

    localparam int DL    = `RX_MIN_FRAME;
    localparam int CNT_W = $clog2(DL + 1);

    logic [31:0]           crc_q;
    logic                  err_q;
    logic [CNT_W-1:0]      cnt_q;
    eth_rx_pkg::mii_byte_t dl_q [DL];
    logic                  line_full;
    logic                  frame_bad;

    // one byte through the reflected crc-32, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ eth_rx_pkg::CRC32_POLY) : (c >> 1);
        end
        return c;
    endfunction

    assign line_full = (cnt_q == CNT_W'(DL));

    // a dangling nibble always raises frame_end_odd
    assign frame_bad = (crc_q != eth_rx_pkg::CRC32_RESIDUE) | err_q | frame_end_odd;

    // ==============================
    // crc, error and byte count
    // ==============================

    always_ff @(posedge rx_clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_q      <= '1;
            err_q      <= 1'b0;
            cnt_q      <= '0;
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= 1'b0;
            if (byte_valid) begin
                if (byte_in.sof) begin
                    crc_q <= crc_byte('1, byte_in.data);
                    err_q <= byte_in.err;
                    cnt_q <= CNT_W'(1);
                end else begin
                    crc_q <= crc_byte(crc_q, byte_in.data);
                    err_q <= err_q | byte_in.err;
                    if (!line_full) begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                    // oldest byte is payload once five follow it
                    beat_valid <= line_full;
                end
            end else if (frame_end) begin
                // runts leave nothing to send
                beat_valid <= line_full;
                cnt_q      <= '0;
            end
        end
    end

    // ==============================
    // fcs delay line
    // ==============================

    always_ff @(posedge rx_clk) begin
        if (byte_valid) begin
            dl_q[0] <= byte_in;
            for (int i = 1; i < DL; i++) begin
                dl_q[i] <= dl_q[i-1];
            end
            beat.data <= dl_q[DL-1].data;
            beat.sop  <= dl_q[DL-1].sof;
            beat.eop  <= 1'b0;
            beat.bad  <= 1'b0;
        end else if (frame_end) begin
            beat.data <= dl_q[DL-1].data;
            beat.sop  <= dl_q[DL-1].sof;
            beat.eop  <= 1'b1;
            beat.bad  <= frame_bad;
        end
    end

endmodule

`default_nettype wire

//--- logic/rx_credit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_cfg.svh"

module rx_credit_fifo (
    input  wire                        rx_clk,
    input  wire                        rst_n,
    input  wire eth_rx_pkg::eth_beat_t in_beat,
    input  wire                        in_valid,
    input  wire                        credit_return,
    output eth_rx_pkg::eth_beat_t      out_beat,
    output logic                       out_valid,
    output logic                       overflow
);

    localparam int DEPTH = `RX_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = $clog2(`RX_CREDITS_INIT + 1);

    eth_rx_pkg::eth_beat_t mem [DEPTH];

    // extra msb tells full from empty
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic [CW-1:0] credits;
    logic          full;
    logic          empty;
    logic          wr_en;
    logic          rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign wr_en = in_valid & ~full;
    assign rd_en = ~empty & (credits != '0);

    // ==============================
    // storage
    // ==============================

    always_ff @(posedge rx_clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= in_beat;
        end
        if (rd_en) begin
            out_beat <= mem[rd_ptr[AW-1:0]];
        end
    end

    // ==============================
    // pointers and credits
    // ==============================

    always_ff @(posedge rx_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            credits   <= CW'(`RX_CREDITS_INIT);
            out_valid <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            out_valid <= rd_en;
            // mii cannot stall, byte is lost
            overflow  <= in_valid & full;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // take and return together cancel
            case ({rd_en, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/eth_mii_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module eth_mii_rx_top (
    input  wire                   rx_clk,
    input  wire                   rst_n,
    input  wire                   rx_dv,
    input  wire                   rx_er,
    input  wire [3:0]             rxd,
    input  wire                   credit_return,
    output eth_rx_pkg::eth_beat_t out_beat,
    output logic                  out_valid,
    output logic                  overflow
);

    eth_rx_pkg::mii_byte_t mii_byte;
    logic                  byte_valid;
    logic                  frame_end;
    logic                  frame_end_odd;
    eth_rx_pkg::eth_beat_t beat;
    logic                  beat_valid;

    mii_nibble_decoder decoder_i (
        .rx_clk        (rx_clk),
        .rst_n         (rst_n),
        .rx_dv         (rx_dv),
        .rx_er         (rx_er),
        .rxd           (rxd),
        .byte_out      (mii_byte),
        .byte_valid    (byte_valid),
        .frame_end     (frame_end),
        .frame_end_odd (frame_end_odd)
    );

    frame_crc_checker checker_i (
        .rx_clk        (rx_clk),
        .rst_n         (rst_n),
        .byte_in       (mii_byte),
        .byte_valid    (byte_valid),
        .frame_end     (frame_end),
        .frame_end_odd (frame_end_odd),
        .beat          (beat),
        .beat_valid    (beat_valid)
    );

    rx_credit_fifo fifo_i (
        .rx_clk        (rx_clk),
        .rst_n         (rst_n),
        .in_beat       (beat),
        .in_valid      (beat_valid),
        .credit_return (credit_return),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .overflow      (overflow)
    );

endmodule

`default_nettype wire

//--- dv/eth_mii_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_cfg.svh"

module eth_mii_rx_tb;

    // one frame per row, exp_bad is the status expected on eop
    typedef struct packed {
        logic [7:0] len;
        logic [7:0] pre;
        logic       corrupt;
        logic [7:0] er_idx;
        logic       odd;
        logic       exp_bad;
    } frame_row_t;

    localparam logic [7:0] NO_ER = 8'hFF;

    logic                  rx_clk;
    logic                  rst_n;
    logic                  rx_dv;
    logic                  rx_er;
    logic [3:0]            rxd;
    logic                  credit_return;
    eth_rx_pkg::eth_beat_t out_beat;
    logic                  out_valid;
    logic                  overflow;

    frame_row_t            rows [$];
    eth_rx_pkg::eth_beat_t exp_q [$];
    int                    credit_due [$];
    int                    tb_credits   = `RX_CREDITS_INIT;
    int                    cycle        = 0;
    int                    beat_errors  = 0;
    int                    flag_errors  = 0;
    int                    other_errors = 0;
    int                    beats_seen   = 0;
    logic                  ovf_seen     = 1'b0;

    eth_mii_rx_top dut_i (
        .rx_clk        (rx_clk),
        .rst_n         (rst_n),
        .rx_dv         (rx_dv),
        .rx_er         (rx_er),
        .rxd           (rxd),
        .credit_return (credit_return),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .overflow      (overflow)
    );

    initial begin
        rx_clk = 1'b0;
        forever #5 rx_clk = ~rx_clk;
    end

    // ==============================
    // models and compare tasks
    // ==============================

    // bit-serial reflected crc, data lsb first
    function automatic logic [31:0] crc_bits(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] r;
        logic        fb;
        r = crc;
        for (int k = 0; k < 8; k++) begin
            fb = r[0] ^ data[k];
            r  = r >> 1;
            if (fb) begin
                r = r ^ eth_rx_pkg::CRC32_POLY;
            end
        end
        return r;
    endfunction

    task automatic check_beat(input string name, input eth_rx_pkg::eth_beat_t got,
                              input eth_rx_pkg::eth_beat_t exp);
        eth_rx_pkg::eth_beat_t g;
        g = got;
        // status only counts on eop
        if (!exp.eop) begin
            g.bad = exp.bad;
        end
        if (g !== exp) begin
            beat_errors++;
            $display("FAILED %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("FAILED %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic add_row(input int len, input int pre, input logic corrupt,
                           input int er_idx, input logic odd, input logic exp_bad);
        rows.push_back('{len: 8'(len), pre: 8'(pre), corrupt: corrupt,
                         er_idx: 8'(er_idx), odd: odd, exp_bad: exp_bad});
    endtask

    // ==============================
    // mii driver
    // ==============================

    task automatic drive_nibble(input logic dv, input logic [3:0] nib, input logic er);
        @(negedge rx_clk);
        rx_dv = dv;
        rxd   = nib;
        rx_er = er;
    endtask

    task automatic send_frame(input frame_row_t row);
        logic [7:0]            fbytes [0:63];
        logic [31:0]           crc;
        eth_rx_pkg::eth_beat_t b;
        int                    nbytes;
        int                    nib;
        int                    i;
        nbytes = int'(row.len) + 4;
        crc = '1;
        for (i = 0; i < int'(row.len); i++) begin
            fbytes[i] = 8'($urandom);
            crc = crc_bits(crc, fbytes[i]);
        end
        crc = ~crc;
        for (i = 0; i < 4; i++) begin
            fbytes[int'(row.len) + i] = crc[8*i +: 8];
        end
        if (row.corrupt) begin
            fbytes[row.len] ^= 8'h10;
        end
        // runts deliver nothing
        if (nbytes >= `RX_MIN_FRAME) begin
            for (i = 0; i < int'(row.len); i++) begin
                b.data = fbytes[i];
                b.sop  = (i == 0);
                b.eop  = (i == int'(row.len) - 1);
                b.bad  = b.eop & row.exp_bad;
                exp_q.push_back(b);
            end
        end
        for (i = 0; i < int'(row.pre); i++) begin
            drive_nibble(1'b1, 4'h5, 1'b0);
        end
        drive_nibble(1'b1, 4'hD, 1'b0);
        nib = 0;
        for (i = 0; i < nbytes; i++) begin
            drive_nibble(1'b1, fbytes[i][3:0], nib == int'(row.er_idx));
            drive_nibble(1'b1, fbytes[i][7:4], nib + 1 == int'(row.er_idx));
            nib += 2;
        end
        if (row.odd) begin
            drive_nibble(1'b1, 4'($urandom), nib == int'(row.er_idx));
        end
        repeat (12) drive_nibble(1'b0, 4'h0, 1'b0);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 1000) begin
            @(negedge rx_clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("timeout: %0d expected beats never arrived", exp_q.size());
            exp_q.delete();
        end
    endtask

    // ==============================
    // credit-returning sink
    // ==============================

    initial begin : sink
        eth_rx_pkg::eth_beat_t exp;
        int                    idx;
        credit_return = 1'b0;
        forever begin
            @(negedge rx_clk);
            cycle++;
            credit_return = 1'b0;
            if (rst_n) begin
                if (overflow) begin
                    ovf_seen = 1'b1;
                end
                if (out_valid) begin
                    check_flag("credit_available", tb_credits != 0, 1'b1);
                    tb_credits--;
                    beats_seen++;
                    if (exp_q.size() == 0) begin
                        other_errors++;
                        $display("beat %h arrived with nothing expected", out_beat);
                    end else begin
                        exp = exp_q.pop_front();
                        check_beat("out_beat", out_beat, exp);
                    end
                    credit_due.push_back(cycle + int'($urandom_range(20, 0)));
                end
                // at most one credit back per cycle
                idx = -1;
                for (int k = 0; k < credit_due.size(); k++) begin
                    if (idx < 0 && credit_due[k] <= cycle) begin
                        idx = k;
                    end
                end
                if (idx >= 0) begin
                    credit_due.delete(idx);
                    credit_return = 1'b1;
                    tb_credits++;
                end
            end
        end
    end

    // ==============================
    // frame table and main sequence
    // ==============================

    initial begin : main
        void'($urandom(32'h7e6b_a0ca));
        rst_n = 1'b0;
        rx_dv = 1'b0;
        rx_er = 1'b0;
        rxd   = 4'h0;

        //       len pre crc er_idx odd bad
        add_row(46, 15, 1'b0, NO_ER, 1'b0, 1'b0);
        add_row( 1, 15, 1'b0, NO_ER, 1'b0, 1'b0);
        add_row(60, 15, 1'b0, NO_ER, 1'b0, 1'b0);
        add_row(20, 15, 1'b1, NO_ER, 1'b0, 1'b1);
        add_row(20, 15, 1'b0,     7, 1'b0, 1'b1);
        // rx_er inside the fcs
        add_row(20, 15, 1'b0,    45, 1'b0, 1'b1);
        add_row(20, 15, 1'b0, NO_ER, 1'b1, 1'b1);
        add_row( 0, 15, 1'b0, NO_ER, 1'b0, 1'b0);
        add_row( 0, 15, 1'b0, NO_ER, 1'b1, 1'b0);
        add_row(12, 15, 1'b0, NO_ER, 1'b0, 1'b0);
        add_row(16,  1, 1'b0, NO_ER, 1'b0, 1'b0);
        add_row(16,  3, 1'b0, NO_ER, 1'b0, 1'b0);
        add_row(30,  7, 1'b0, NO_ER, 1'b0, 1'b0);
        // rx_er on the dangling nibble
        add_row(10, 15, 1'b0,    28, 1'b1, 1'b1);
        add_row(60, 15, 1'b0, NO_ER, 1'b0, 1'b0);

        repeat (16) @(negedge rx_clk);
        rst_n = 1'b1;
        repeat (4) @(negedge rx_clk);

        for (int r = 0; r < rows.size(); r++) begin
            send_frame(rows[r]);
            wait_drained();
        end
        repeat (30) @(negedge rx_clk);
        check_flag("overflow", ovf_seen, 1'b0);

        $display("beats %0d, beat errors %0d, flag errors %0d, other errors %0d",
                 beats_seen, beat_errors, flag_errors, other_errors);
        if (beat_errors + flag_errors + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- eth_mii_rx_top.f
+incdir+common
common/eth_rx_pkg.sv
mii_rx/mii_nibble_decoder.sv
logic/frame_crc_checker.sv
logic/rx_credit_fifo.sv
logic/eth_mii_rx_top.sv
dv/eth_mii_rx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the receive path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_LOG=build.log

rm -rf obj_dir "$LOG" "$BUILD_LOG"

verilator --binary --timing -Wno-fatal -f eth_mii_rx_top.f \
    --top-module eth_mii_rx_tb -o eth_mii_rx_sim > "$BUILD_LOG" 2>&1 \
    && ./obj_dir/eth_mii_rx_sim > "$LOG" 2>&1 \
    || { cat "$BUILD_LOG" "$LOG" 2>/dev/null; echo "build or run error"; exit 1; }

cat "$LOG"
grep -q "CHECKS FAILED" "$LOG" && { echo "simulation failed"; exit 1; } || exit 0
